/* Makefile */
# Verilator build and run of the pipeline testbench
VERILATOR ?= verilator
TOP       ?= rv_pipeline_tb
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/rv_pipeline_properties.sv */
`include "cpu_config.svh"

module rv_pipeline_properties (
  input logic                 clk,
  input logic                 reset,
  input logic                 wb_valid,
  input rv_isa_pkg::reg_idx_t wb_rd,
  input rv_isa_pkg::word_t    wb_data,
  input logic                 is_halted
);

  int fail_count = 0;  // assertion failures so far

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_rd != '0)
    else begin
      $error("wb_valid high with wb_rd of zero");
      fail_count++;
    end

  // outputs settle low once reset has been seen for a cycle
  quiet_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> !wb_valid && !is_halted)
    else begin
      $error("wb_valid or is_halted high during reset");
      fail_count++;
    end

  known_wb_data: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> !$isunknown(wb_data))
    else begin
      $error("wb_data has unknown bits while wb_valid is high");
      fail_count++;
    end

endmodule

bind rv_pipeline_top rv_pipeline_properties props0 (
  .clk       (clk),
  .reset     (reset),
  .wb_valid  (wb_valid),
  .wb_rd     (wb_rd),
  .wb_data   (wb_data),
  .is_halted (is_halted)
);

/* bench/rv_pipeline_tb.sv */
`include "cpu_config.svh"

module rv_pipeline_tb;

  localparam int PROG_LEN = 40;

  // instruction kinds shared by the generator and the model
  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI,
    K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_ECALL
  } kind_e;

  logic                                clk;
  logic                                gen_reset;
  logic                                loading;
  logic                                reset;
  logic                                load_en;
  logic [$clog2(`IMEM_DEPTH)-1:0]      load_addr;
  rv_isa_pkg::inst_t                   load_inst;
  logic                                wb_valid;
  rv_isa_pkg::reg_idx_t                wb_rd;
  rv_isa_pkg::word_t                   wb_data;
  logic                                is_halted;

  logic [31:0]       lfsr_state;
  int                kind [PROG_LEN];
  int                f_rd [PROG_LEN];
  int                f_rs1 [PROG_LEN];
  int                f_rs2 [PROG_LEN];
  rv_isa_pkg::word_t f_imm [PROG_LEN];
  rv_isa_pkg::inst_t prog [PROG_LEN];
  int                exp_rd [$];
  rv_isa_pkg::word_t exp_data [$];
  int                exp_cat [$];   // behavior a write belongs to
  int                exp_idx;
  int                chk [1:5];
  int                err [1:5];

  assign reset = gen_reset || loading;  // hold the core while imem loads

  tb_clock #(.PERIOD(10), .RESET_CYCLES(3)) clock0 (.clk(clk), .reset(gen_reset));

  rv_pipeline_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_inst (load_inst),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .is_halted (is_halted)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    logic        nb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      nb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], nb};
      v = (v << 1) | nb;
    end
    return v;
  endfunction

  function automatic int pick_reg();
    return 1 + rand_bits(3);  // x1..x8
  endfunction

  function automatic rv_isa_pkg::inst_t encode(input int i);
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::funct3_t f3;
    rd  = f_rd[i];
    rs1 = f_rs1[i];
    rs2 = f_rs2[i];
    imm = f_imm[i];
    case (kind[i])
      K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT: begin
        case (kind[i])
          K_AND:   f3 = rv_isa_pkg::F3_AND;
          K_OR:    f3 = rv_isa_pkg::F3_OR;
          K_XOR:   f3 = rv_isa_pkg::F3_XOR;
          K_SLT:   f3 = rv_isa_pkg::F3_SLT;
          default: f3 = rv_isa_pkg::F3_ADD_SUB;
        endcase
        return {(kind[i] == K_SUB) ? rv_isa_pkg::F7_SUB : rv_isa_pkg::F7_BASE,
                rs2, rs1, f3, rd, rv_isa_pkg::OP};
      end
      K_ADDI: return {imm[11:0], rs1, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OP_IMM};
      K_LW:   return {imm[11:0], rs1, rv_isa_pkg::F3_LW, rd, rv_isa_pkg::LOAD};
      K_SW:   return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_SW, imm[4:0], rv_isa_pkg::STORE};
      K_BEQ, K_BNE: begin
        f3 = (kind[i] == K_BNE) ? rv_isa_pkg::F3_BNE : rv_isa_pkg::F3_BEQ;
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
      end
      K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL};
      default: return rv_isa_pkg::ECALL_INST;
    endcase
  endfunction

  task automatic set_inst(input int i, input int k, input int rd, input int rs1,
                          input int rs2, input int imm);
    kind[i]  = k;
    f_rd[i]  = rd;
    f_rs1[i] = rs1;
    f_rs2[i] = rs2;
    f_imm[i] = rv_isa_pkg::word_t'(imm);
  endtask

  // setup stores, an early ecall, a random body, then the halt pair
  task automatic build_program();
    int r;
    int prev_rd;
    int rs1;
    int span;
    for (int i = 0; i < 4; i++) begin
      set_inst(i, K_ADDI, i + 1, 0, 0, int'($signed(12'(rand_bits(12)))));
    end
    for (int i = 4; i < 8; i++) set_inst(i, K_SW, 0, 0, i - 3, 4 * (i - 4));
    set_inst(8, K_ECALL, 0, 0, 0, 0);  // x17 still zero here
    prev_rd = 1;
    for (int i = 9; i < PROG_LEN - 2; i++) begin
      r    = rand_bits(4);
      rs1  = rand_bits(1) ? prev_rd : pick_reg();  // lean on back to back dependences
      span = 2 + rand_bits(2) % 3;
      if (r < 6) begin
        set_inst(i, K_ADD + r, pick_reg(), rs1, pick_reg(), 0);
      end else if (r == 8 || r == 9) begin
        set_inst(i, K_LW, pick_reg(), 0, 0, 4 * rand_bits(2));
      end else if (r == 10) begin
        set_inst(i, K_SW, 0, 0, rs1, 4 * rand_bits(2));
      end else if ((r == 11 || r == 12) && i + span <= PROG_LEN - 2) begin
        set_inst(i, (r == 11) ? K_BEQ : K_BNE, 0, rs1, rand_bits(1) ? rs1 : pick_reg(),
                 4 * span);
      end else if (r == 13 && i + span <= PROG_LEN - 2) begin
        set_inst(i, K_JAL, pick_reg(), 0, 0, 4 * span);
      end else begin
        set_inst(i, K_ADDI, pick_reg(), rs1, 0, int'($signed(12'(rand_bits(12)))));
      end
      if (f_rd[i] != 0) prev_rd = f_rd[i];
    end
    set_inst(PROG_LEN - 2, K_ADDI, `HALT_REG, 0, 0, `HALT_CODE);
    set_inst(PROG_LEN - 1, K_ECALL, 0, 0, 0, 0);
    for (int i = 0; i < PROG_LEN; i++) prog[i] = encode(i);
  endtask

  // instruction-set model stepping through the program
  task automatic run_model();
    rv_isa_pkg::word_t regs [32];
    rv_isa_pkg::word_t mem [4];
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t res;
    int                pc;
    int                i;
    int                steps;
    int                cat;
    bit                done;
    for (int j = 0; j < 32; j++) regs[j] = '0;
    for (int j = 0; j < 4; j++) mem[j] = '0;
    pc = 0;
    steps = 0;
    done = 0;
    while (!done && steps < 400 && pc / 4 < PROG_LEN) begin
      i = pc / 4;
      a = regs[f_rs1[i]];
      b = regs[f_rs2[i]];
      pc = pc + 4;
      case (kind[i])
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI: cat = 1;
        K_LW:    cat = 2;
        K_JAL:   cat = 3;
        default: cat = 0;
      endcase
      case (kind[i])
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
        K_ADDI: res = a + f_imm[i];
        K_LW:   res = mem[f_imm[i] / 4];
        K_SW:   mem[f_imm[i] / 4] = b;
        K_BEQ:  if (a == b) pc = pc - 4 + f_imm[i];
        K_BNE:  if (a != b) pc = pc - 4 + f_imm[i];
        K_JAL: begin
          res = pc;
          pc  = pc - 4 + f_imm[i];
        end
        default: done = (regs[`HALT_REG] == `HALT_CODE);
      endcase
      if (cat != 0 && f_rd[i] != 0) begin
        regs[f_rd[i]] = res;
        exp_rd.push_back(f_rd[i]);
        exp_data.push_back(res);
        exp_cat.push_back(cat);
      end
      steps++;
    end
  endtask

  task automatic check_write();
    int cat;
    if (exp_idx >= exp_rd.size()) begin
      $display("unexpected write to x%0d after the program's last write", wb_rd);
      err[3]++;
    end else begin
      cat = exp_cat[exp_idx];
      chk[cat]++;
      assert (wb_rd == exp_rd[exp_idx]) else begin
        $display("** Error: wb_rd got %h expected %h", wb_rd, exp_rd[exp_idx][4:0]);
        err[cat]++;
      end
      assert (wb_data == exp_data[exp_idx]) else begin
        $display("** Error: wb_data got %h expected %h", wb_data, exp_data[exp_idx]);
        err[cat]++;
      end
      exp_idx++;
    end
  endtask

  initial begin
    int  cycles;
    int  total_chk;
    int  total_err;
    bit  halted;
    load_en    = 1'b0;
    load_addr  = '0;
    load_inst  = '0;
    loading    = 1'b1;
    lfsr_state = 32'hf23a_00f4;
    exp_idx    = 0;
    for (int b = 1; b <= 5; b++) begin
      chk[b] = 0;
      err[b] = 0;
    end
    build_program();
    run_model();

    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= a[$clog2(`IMEM_DEPTH)-1:0];
      load_inst <= (a < PROG_LEN) ? prog[a] : rv_isa_pkg::NOP_INST;  // pad with nops
    end
    @(posedge clk);
    load_en <= 1'b0;
    cycles = 0;
    while (gen_reset && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (gen_reset) begin
      $display("reset generator never released reset");
      err[5]++;
    end
    loading <= 1'b0;

    // nothing can reach writeback in the first cycles
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      chk[5]++;
      assert (!wb_valid && !is_halted) else begin
        $display("** Error: wb_valid %h is_halted %h expected 0 after reset",
                 wb_valid, is_halted);
        err[5]++;
      end
      if (wb_valid) check_write();
    end
    $display("behavior 5 quiet after reset: %0d checks, %0d errors", chk[5], err[5]);

    halted = 0;
    cycles = 0;
    while (!halted && cycles < 500) begin
      @(negedge clk);
      cycles++;
      if (wb_valid) check_write();
      if (is_halted) begin
        chk[4]++;
        if (exp_idx == exp_rd.size()) begin
          halted = 1;
        end else begin
          $display("is_halted raised with %0d of %0d writes seen", exp_idx, exp_rd.size());
          err[4]++;
        end
      end
    end
    if (!halted) begin
      $display("timed out after 500 cycles waiting for is_halted");
      err[4]++;
    end
    $display("behavior 1 alu and addi results: %0d checks, %0d errors", chk[1], err[1]);
    $display("behavior 2 loads of stored words: %0d checks, %0d errors", chk[2], err[2]);
    $display("behavior 3 skipped code and jal link: %0d checks, %0d errors", chk[3], err[3]);
    $display("behavior 4 halt on ecall: %0d checks, %0d errors", chk[4], err[4]);
    $display("bound properties: %0d failures", dut0.props0.fail_count);

    total_chk = 0;
    total_err = dut0.props0.fail_count;
    for (int b = 1; b <= 5; b++) begin
      total_chk += chk[b];
      total_err += err[b];
    end
    $display("checks %0d, errors %0d", total_chk, total_err);
    if (total_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* include/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_ADDR_W  5

// memory depths in 32-bit words
`define IMEM_DEPTH  64
`define DMEM_DEPTH  32

`define RESET_PC    0

// ecall halts when this register holds the code
`define HALT_REG    17
`define HALT_CODE   10

`endif

/* logic/decode_stage.sv */
`include "cpu_config.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  rv_isa_pkg::inst_t      fd_inst,
  input  rv_isa_pkg::word_t      fd_pc,
  input  logic                   fd_valid,
  input  logic                   redirect,
  input  logic                   wb_valid,
  input  rv_isa_pkg::reg_idx_t   wb_rd,
  input  rv_isa_pkg::word_t      wb_data,
  output logic                   stall,
  output logic                   de_valid,
  output logic                   de_reg_write,
  output logic                   de_mem_read,
  output logic                   de_mem_write,
  output logic                   de_alu_src,
  output logic                   de_branch,
  output logic                   de_bne,
  output logic                   de_jal,
  output pipe_ctrl_pkg::alu_op_e de_alu_op,
  output rv_isa_pkg::reg_idx_t   de_rs1,
  output rv_isa_pkg::reg_idx_t   de_rs2,
  output rv_isa_pkg::word_t      de_rs1_data,
  output rv_isa_pkg::word_t      de_rs2_data,
  output rv_isa_pkg::word_t      de_imm,
  output rv_isa_pkg::word_t      de_pc,
  output rv_isa_pkg::reg_idx_t   de_rd,
  output logic                   de_halt
);

  rv_isa_pkg::opcode_e    opcode;
  rv_isa_pkg::funct3_t    funct3;
  rv_isa_pkg::reg_idx_t   rs1;
  rv_isa_pkg::reg_idx_t   rs2;
  rv_isa_pkg::word_t      rs1_data;
  rv_isa_pkg::word_t      rs2_data;
  rv_isa_pkg::word_t      imm;
  rv_isa_pkg::word_t      regs [2**`REG_ADDR_W];
  pipe_ctrl_pkg::alu_op_e alu_op;
  logic reg_write, mem_read, mem_write, alu_src;
  logic branch, bne, jal, ecall, use_rs1, use_rs2;

  assign opcode = rv_isa_pkg::opcode_e'(fd_inst[6:0]);
  assign funct3 = fd_inst[14:12];
  assign rs1    = ecall ? rv_isa_pkg::reg_idx_t'(`HALT_REG) : fd_inst[19:15];
  assign rs2    = fd_inst[24:20];

  always_comb begin
    {reg_write, mem_read, mem_write, alu_src} = 4'b0;
    {branch, bne, jal, ecall, use_rs1, use_rs2} = 6'b0;
    alu_op = pipe_ctrl_pkg::ADD;
    imm = {{20{fd_inst[31]}}, fd_inst[31:20]};               // I type
    case (opcode)
      rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: begin
        reg_write = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = (opcode == rv_isa_pkg::OP);
        alu_src   = (opcode == rv_isa_pkg::OP_IMM);
        if (funct3 == rv_isa_pkg::F3_SLT) alu_op = pipe_ctrl_pkg::SLT;
        else if (funct3 == rv_isa_pkg::F3_XOR) alu_op = pipe_ctrl_pkg::XOR;
        else if (funct3 == rv_isa_pkg::F3_OR) alu_op = pipe_ctrl_pkg::OR;
        else if (funct3 == rv_isa_pkg::F3_AND) alu_op = pipe_ctrl_pkg::AND;
        else if (use_rs2 && fd_inst[31:25] == rv_isa_pkg::F7_SUB) alu_op = pipe_ctrl_pkg::SUB;
      end
      rv_isa_pkg::LOAD: begin
        {reg_write, mem_read, alu_src, use_rs1} = 4'b1111;
      end
      rv_isa_pkg::STORE: begin
        {mem_write, alu_src, use_rs1, use_rs2} = 4'b1111;
        imm = {{20{fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]};
      end
      rv_isa_pkg::BRANCH: begin
        {branch, use_rs1, use_rs2} = 3'b111;
        bne = (funct3 == rv_isa_pkg::F3_BNE);
        imm = {{19{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25], fd_inst[11:8], 1'b0};
      end
      rv_isa_pkg::JAL: begin
        {jal, reg_write} = 2'b11;
        imm = {{11{fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
               fd_inst[30:21], 1'b0};
      end
      rv_isa_pkg::SYSTEM: begin
        {ecall, use_rs1} = 2'b11;   // halt check on x17 happens in execute
      end
      default: ;                    // unknown word behaves as a nop
    endcase
  end

  // load in execute feeding this instruction costs one bubble
  assign stall = fd_valid && de_mem_read && de_rd != '0 &&
                 ((use_rs1 && rs1 == de_rd) || (use_rs2 && rs2 == de_rd));

  function automatic rv_isa_pkg::word_t reg_read(input rv_isa_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    if (wb_valid && wb_rd == idx) return wb_data;  // same cycle write bypass
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = reg_read(rs1);
    rs2_data = reg_read(rs2);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid) begin    // wb_valid never carries x0
      regs[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect || stall) begin
      de_valid <= 1'b0;
      {de_reg_write, de_mem_read, de_mem_write, de_alu_src} <= 4'b0;
      {de_branch, de_bne, de_jal, de_halt} <= 4'b0;
    end else begin
      de_valid     <= fd_valid;
      de_reg_write <= fd_valid & reg_write;
      de_mem_read  <= fd_valid & mem_read;
      de_mem_write <= fd_valid & mem_write;
      de_alu_src   <= alu_src;
      de_branch    <= fd_valid & branch;
      de_bne       <= bne;
      de_jal       <= fd_valid & jal;
      de_halt      <= fd_valid & ecall;
    end
    de_alu_op   <= alu_op;
    de_rs1      <= rs1;
    de_rs2      <= rs2;
    de_rs1_data <= rs1_data;
    de_rs2_data <= rs2_data;
    de_imm      <= imm;
    de_pc       <= fd_pc;
    de_rd       <= fd_inst[11:7];
  end

endmodule

/* logic/execute_stage.sv */
`include "cpu_config.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   de_valid,
  input  logic                   de_reg_write,
  input  logic                   de_mem_read,
  input  logic                   de_mem_write,
  input  logic                   de_alu_src,
  input  logic                   de_branch,
  input  logic                   de_bne,
  input  logic                   de_jal,
  input  pipe_ctrl_pkg::alu_op_e de_alu_op,
  input  rv_isa_pkg::reg_idx_t   de_rs1,
  input  rv_isa_pkg::reg_idx_t   de_rs2,
  input  rv_isa_pkg::word_t      de_rs1_data,
  input  rv_isa_pkg::word_t      de_rs2_data,
  input  rv_isa_pkg::word_t      de_imm,
  input  rv_isa_pkg::word_t      de_pc,
  input  rv_isa_pkg::reg_idx_t   de_rd,
  input  logic                   de_halt,
  input  logic                   wb_valid,
  input  rv_isa_pkg::reg_idx_t   wb_rd,
  input  rv_isa_pkg::word_t      wb_data,
  output logic                   redirect,
  output rv_isa_pkg::word_t      redirect_pc,
  output logic                   ex_valid,
  output logic                   ex_mem_read,
  output logic                   ex_mem_write,
  output logic                   ex_reg_write,
  output logic                   ex_link,
  output rv_isa_pkg::word_t      ex_alu,
  output rv_isa_pkg::word_t      ex_store_data,
  output rv_isa_pkg::word_t      ex_pc4,
  output rv_isa_pkg::reg_idx_t   ex_rd,
  output logic                   ex_halt
);

  pipe_ctrl_pkg::fwd_sel_e sel_a;
  pipe_ctrl_pkg::fwd_sel_e sel_b;
  rv_isa_pkg::word_t       mem_fwd;
  rv_isa_pkg::word_t       fwd_a;
  rv_isa_pkg::word_t       fwd_b;
  rv_isa_pkg::word_t       op_b;
  rv_isa_pkg::word_t       alu_res;
  logic                    taken;

  assign mem_fwd = ex_link ? ex_pc4 : ex_alu;  // jal result is its link address

  // the younger result in memory beats writeback
  function automatic pipe_ctrl_pkg::fwd_sel_e fwd_sel(input rv_isa_pkg::reg_idx_t rs);
    if (ex_valid && ex_reg_write && !ex_mem_read && rs != '0 && ex_rd == rs)
      return pipe_ctrl_pkg::FROM_MEM;
    if (wb_valid && wb_rd == rs)
      return pipe_ctrl_pkg::FROM_WB;
    return pipe_ctrl_pkg::REGFILE;
  endfunction

  always_comb begin
    sel_a = fwd_sel(de_rs1);
    sel_b = fwd_sel(de_rs2);
    case (sel_a)
      pipe_ctrl_pkg::FROM_MEM: fwd_a = mem_fwd;
      pipe_ctrl_pkg::FROM_WB:  fwd_a = wb_data;
      default:                 fwd_a = de_rs1_data;
    endcase
    case (sel_b)
      pipe_ctrl_pkg::FROM_MEM: fwd_b = mem_fwd;
      pipe_ctrl_pkg::FROM_WB:  fwd_b = wb_data;
      default:                 fwd_b = de_rs2_data;
    endcase
  end

  assign op_b = de_alu_src ? de_imm : fwd_b;

  always_comb begin
    case (de_alu_op)
      pipe_ctrl_pkg::SUB: alu_res = fwd_a - op_b;
      pipe_ctrl_pkg::AND: alu_res = fwd_a & op_b;
      pipe_ctrl_pkg::OR:  alu_res = fwd_a | op_b;
      pipe_ctrl_pkg::XOR: alu_res = fwd_a ^ op_b;
      pipe_ctrl_pkg::SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
      default:            alu_res = fwd_a + op_b;
    endcase
  end

  assign taken       = de_jal || (de_branch && ((fwd_a == fwd_b) ^ de_bne));
  assign redirect    = de_valid && taken;
  assign redirect_pc = de_pc + de_imm;  // branch and jal share pc relative target

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      {ex_mem_read, ex_mem_write, ex_reg_write, ex_link, ex_halt} <= 5'b0;
    end else begin
      ex_valid     <= de_valid;
      ex_mem_read  <= de_mem_read;
      ex_mem_write <= de_mem_write;
      ex_reg_write <= de_reg_write;
      ex_link      <= de_jal;
      ex_halt      <= de_valid && de_halt && fwd_a == rv_isa_pkg::word_t'(`HALT_CODE);
    end
    ex_alu        <= alu_res;
    ex_store_data <= fwd_b;
    ex_pc4        <= de_pc + rv_isa_pkg::word_t'(4);
    ex_rd         <= de_rd;
  end

endmodule

/* logic/fetch_stage.sv */
`include "cpu_config.svh"

module fetch_stage (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load_en,
  input  logic [$clog2(`IMEM_DEPTH)-1:0]      load_addr,
  input  rv_isa_pkg::inst_t                   load_inst,
  input  logic                                stall,
  input  logic                                redirect,
  input  rv_isa_pkg::word_t                   redirect_pc,
  output rv_isa_pkg::inst_t                   fd_inst,
  output rv_isa_pkg::word_t                   fd_pc,
  output logic                                fd_valid
);

  localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

  rv_isa_pkg::word_t pc;
  rv_isa_pkg::inst_t imem [`IMEM_DEPTH];
  rv_isa_pkg::inst_t inst;

  assign inst = imem[pc[IMEM_AW+1:2]];  // word addressed, async read

  always_ff @(posedge clk) begin
    if (load_en) begin
      imem[load_addr] <= load_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_isa_pkg::word_t'(`RESET_PC);
    end else if (redirect) begin      // taken branch wins over stall
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + rv_isa_pkg::word_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      fd_valid <= 1'b0;
    end else if (!stall) begin
      fd_valid <= 1'b1;
      fd_inst  <= inst;
      fd_pc    <= pc;
    end
  end

endmodule

/* logic/memory_stage.sv */
`include "cpu_config.svh"

module memory_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ex_valid,
  input  logic                 ex_mem_read,
  input  logic                 ex_mem_write,
  input  logic                 ex_reg_write,
  input  logic                 ex_link,
  input  rv_isa_pkg::word_t    ex_alu,
  input  rv_isa_pkg::word_t    ex_store_data,
  input  rv_isa_pkg::word_t    ex_pc4,
  input  rv_isa_pkg::reg_idx_t ex_rd,
  input  logic                 ex_halt,
  output logic                 wb_valid,
  output rv_isa_pkg::reg_idx_t wb_rd,
  output rv_isa_pkg::word_t    wb_data,
  output logic                 is_halted
);

  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  rv_isa_pkg::word_t dmem [`DMEM_DEPTH];
  rv_isa_pkg::word_t load_data;

  assign load_data = dmem[ex_alu[DMEM_AW+1:2]];  // word aligned accesses only

  always_ff @(posedge clk) begin
    if (ex_valid && ex_mem_write) begin
      dmem[ex_alu[DMEM_AW+1:2]] <= ex_store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid  <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      wb_valid  <= ex_valid && ex_reg_write && ex_rd != '0;
      is_halted <= ex_valid && ex_halt;
    end
    wb_rd   <= ex_rd;
    wb_data <= ex_mem_read ? load_data : (ex_link ? ex_pc4 : ex_alu);
  end

endmodule

/* logic/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

  // operations the execute stage can perform
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT
  } alu_op_e;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    REGFILE,   // value read in decode
    FROM_MEM,  // execute/memory register
    FROM_WB    // memory/writeback register
  } fwd_sel_e;

endpackage

/* logic/rv_isa_pkg.sv */
`include "cpu_config.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [31:0] inst_t;              // rv32 encoding is fixed width
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // base opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  localparam funct3_t F3_ADD_SUB = 3'b000;  // also addi
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_LW      = 3'b010;
  localparam funct3_t F3_SW      = 3'b010;
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;
  localparam funct3_t F3_ECALL   = 3'b000;

  localparam funct7_t F7_BASE    = 7'b0000000;
  localparam funct7_t F7_SUB     = 7'b0100000;

  localparam inst_t ECALL_INST   = 32'h0000_0073;
  localparam inst_t NOP_INST     = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* logic/rv_pipeline_top.sv */
`include "cpu_config.svh"

module rv_pipeline_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load_en,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
  input  rv_isa_pkg::inst_t              load_inst,
  output logic                           wb_valid,
  output rv_isa_pkg::reg_idx_t           wb_rd,
  output rv_isa_pkg::word_t              wb_data,
  output logic                           is_halted
);

  // fetch/decode register and hazard controls
  rv_isa_pkg::inst_t      fd_inst;
  rv_isa_pkg::word_t      fd_pc;
  logic                   fd_valid;
  logic                   stall;
  logic                   redirect;
  rv_isa_pkg::word_t      redirect_pc;

  // decode/execute register
  logic                   de_valid, de_reg_write, de_mem_read, de_mem_write, de_alu_src;
  logic                   de_branch, de_bne, de_jal, de_halt;
  pipe_ctrl_pkg::alu_op_e de_alu_op;
  rv_isa_pkg::reg_idx_t   de_rs1, de_rs2, de_rd;
  rv_isa_pkg::word_t      de_rs1_data, de_rs2_data, de_imm, de_pc;

  // execute/memory register
  logic                   ex_valid, ex_mem_read, ex_mem_write, ex_reg_write, ex_link, ex_halt;
  rv_isa_pkg::word_t      ex_alu, ex_store_data, ex_pc4;
  rv_isa_pkg::reg_idx_t   ex_rd;

  fetch_stage   fetch0   (.*);
  decode_stage  decode0  (.*);
  execute_stage execute0 (.*);
  memory_stage  memory0  (.*);

endmodule

/* project.f */
+incdir+include
logic/rv_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_pipeline_top.sv
bench/tb_clock.sv
bench/rv_pipeline_properties.sv
bench/rv_pipeline_tb.sv
